// File: hdl/acq_defines.svh
`ifndef ACQ_DEFINES_SVH
`define ACQ_DEFINES_SVH

// adc sample, over-range flag in bit 0
`define ACQ_SAMPLE_W   13
`define ACQ_HALF_W     16    // one sample after sign extension
`define ACQ_WORD_W     32    // two samples per buffer word, also the header word width

////////////////////////////////////////
// sample buffer geometry
`define ACQ_ADDR_W     12
`define ACQ_DEPTH      4096  // physical words, buffer_size may be smaller

// header record
`define ACQ_HDR_WORDS  3     // channel, trigger number, start address
`define ACQ_FIFO_DEPTH 16    // power of two

`endif

// File: hdl/acq_types_pkg.sv
`include "acq_defines.svh"

package acq_types_pkg;

  // raw adc sample as it comes off the pins
  typedef logic [`ACQ_SAMPLE_W-1:0] sample_t;

  // packed pair of sign-extended samples, b in the high half
  typedef logic [`ACQ_WORD_W-1:0] buf_word_t;

  typedef logic [`ACQ_ADDR_W-1:0] buf_addr_t;   // buffer word address

  // sizes and counters, one bit wider than the address so the full depth fits
  typedef logic [`ACQ_ADDR_W:0] word_count_t;

  ////////////////////////////////////////
  // header fields
  typedef logic [`ACQ_WORD_W-1:0] trig_num_t;   // event number
  typedef logic [`ACQ_WORD_W-1:0] chan_num_t;   // channel id

endpackage

// File: hdl/acq_state_pkg.sv
package acq_state_pkg;

  // acquisition controller
  typedef enum logic [2:0] {
    ACQ_IDLE,    // after reset, waits for arm
    ACQ_FILL,    // first pass through the buffer, trig ignored
    ACQ_ARMED,   // circular writing, waits for trig
    ACQ_POST,    // post-trigger words
    ACQ_HEADER,  // one header word per cycle into the fifo
    ACQ_DONE     // record complete, holds until the next arm
  } acq_state_t;

  // readout sequencer
  typedef enum logic [1:0] {
    RD_IDLE,     // waits for a header
    RD_HDR,      // pops the header words
    RD_DATA      // walks the circular data window
  } rd_state_t;

endpackage

// File: hdl/acq_if.sv
interface header_if;
  import acq_types_pkg::*;

  logic      wr_en;   // push one header word
  buf_word_t din;
  logic      rd_en;   // pop, dout valid the next cycle
  buf_word_t dout;
  logic      empty;
  logic      full;    // a push while full is dropped

  // acquisition controller side
  modport writer (output wr_en, output din);

  // storage owner
  modport fifo (
    input  wr_en,
    input  din,
    input  rd_en,
    output dout,
    output empty,
    output full
  );

  // readout side
  modport reader (output rd_en, input dout, input empty);

endinterface

// File: hdl/acq_control.sv
`include "acq_defines.svh"

module acq_control (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       arm,               // restart, any state
  input  logic                       trig,              // only taken in ACQ_ARMED
  input  logic                       trig_num_we,       // load initial_trig_num
  input  acq_types_pkg::word_count_t buffer_size,       // circular window in words
  input  acq_types_pkg::word_count_t post_trig_size,    // words after the trigger word
  input  acq_types_pkg::chan_num_t   channel_num,
  input  acq_types_pkg::trig_num_t   initial_trig_num,
  output logic                       acq_done,          // level, cleared by arm
  output logic                       wr_en,             // sample buffer write
  output acq_types_pkg::buf_addr_t   wr_addr,
  output acq_types_pkg::trig_num_t   current_trig_num,  // number the next trigger takes
  header_if.writer                   hdr
);
  import acq_types_pkg::*;
  import acq_state_pkg::*;

  acq_state_t  state;
  word_count_t cnt;         // shared by fill, post and header phases
  trig_num_t   trig_num;
  buf_addr_t   addr_next;   // wrapped at buffer_size
  logic        last_fill;
  logic        last_post;
  logic        last_hdr;

  // one word per cycle while sampling
  assign wr_en = (state == ACQ_FILL) || (state == ACQ_ARMED) || (state == ACQ_POST);
  assign acq_done = (state == ACQ_DONE);
  assign current_trig_num = trig_num;

  assign addr_next = ({1'b0, wr_addr} == buffer_size - 1'b1) ? '0 : wr_addr + 1'b1;

  assign last_fill = (cnt == buffer_size - 1'b1);
  assign last_post = (cnt == post_trig_size - 1'b1);
  assign last_hdr  = (cnt == word_count_t'(`ACQ_HDR_WORDS - 1));

  ////////////////////////////////////////
  // arm / fill / trigger / post machine
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ACQ_IDLE;
      cnt     <= '0;
      wr_addr <= '0;
    end else if (arm) begin
      state   <= ACQ_FILL;   // start over from address 0
      cnt     <= '0;
      wr_addr <= '0;
    end else begin
      if (wr_en) begin
        wr_addr <= addr_next;
      end
      case (state)
        ACQ_FILL: begin
          if (last_fill) begin
            state <= ACQ_ARMED;  // whole window holds fresh samples
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ACQ_ARMED: begin
          if (trig) begin
            cnt <= '0;
            // trigger word goes in this cycle, no post words means straight to header
            state <= (post_trig_size == '0) ? ACQ_HEADER : ACQ_POST;
          end
        end
        ACQ_POST: begin
          if (last_post) begin
            state <= ACQ_HEADER;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ACQ_HEADER: begin
          if (last_hdr) begin
            state <= ACQ_DONE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: ;  // idle and done wait for arm
      endcase
    end
  end

  // trigger number, load wins over the increment
  always_ff @(posedge clk) begin
    if (reset) begin
      trig_num <= '0;
    end else if (trig_num_we) begin
      trig_num <= initial_trig_num;
    end else if ((state == ACQ_HEADER) && last_hdr) begin
      trig_num <= trig_num + 1'b1;   // after the record has used it
    end
  end

  ////////////////////////////////////////
  // header words
  assign hdr.wr_en = (state == ACQ_HEADER);

  always_comb begin
    case (cnt[1:0])
      2'd0:    hdr.din = channel_num;
      2'd1:    hdr.din = trig_num;
      // wr_addr already points past the last post-trigger word
      default: hdr.din = buf_word_t'(wr_addr);
    endcase
  end

endmodule

// File: hdl/sample_buffer.sv
`include "acq_defines.svh"

module sample_buffer (
  input  logic                     clk,
  input  acq_types_pkg::sample_t   adc_sample_a,   // low half of the word
  input  acq_types_pkg::sample_t   adc_sample_b,   // high half of the word
  input  logic                     wr_en,
  input  acq_types_pkg::buf_addr_t wr_addr,
  input  acq_types_pkg::buf_addr_t rd_addr,
  output acq_types_pkg::buf_word_t rd_data         // one cycle after rd_addr
);
  import acq_types_pkg::*;

  localparam int EXT_W = `ACQ_HALF_W - `ACQ_SAMPLE_W;  // bits of sign to add

  logic [`ACQ_HALF_W-1:0] half_a;
  logic [`ACQ_HALF_W-1:0] half_b;
  buf_word_t              wr_word;

  buf_word_t mem [`ACQ_DEPTH];   // dual port, write side from the controller

  ////////////////////////////////////////
  // sample packing
  // msb of the sample is the sign, over-range bit 0 rides along untouched
  assign half_a = {{EXT_W{adc_sample_a[`ACQ_SAMPLE_W-1]}}, adc_sample_a};
  assign half_b = {{EXT_W{adc_sample_b[`ACQ_SAMPLE_W-1]}}, adc_sample_b};

  assign wr_word = {half_b, half_a};

  ////////////////////////////////////////
  // memory
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: hdl/header_fifo.sv
`include "acq_defines.svh"

module header_fifo #(
  parameter int DEPTH = `ACQ_FIFO_DEPTH   // power of two
) (
  input logic     clk,
  input logic     reset,
  header_if.fifo  hdr
);
  import acq_types_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  buf_word_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;   // wraps on its own
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;    // 0 .. DEPTH
  logic             do_wr;
  logic             do_rd;

  assign do_wr = hdr.wr_en && !hdr.full;    // push while full is lost
  assign do_rd = hdr.rd_en && !hdr.empty;

  assign hdr.empty = (count == '0);
  assign hdr.full  = count[PTR_W];          // top bit only set at DEPTH

  ////////////////////////////////////////
  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither, no change
      endcase
    end
  end

  // storage, dout holds until the next pop
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= hdr.din;
    end
    if (do_rd) begin
      hdr.dout <= mem[rd_ptr];
    end
  end

endmodule

// File: hdl/readout_sequencer.sv
`include "acq_defines.svh"

module readout_sequencer (
  input  logic                       clk,
  input  logic                       reset,
  input  acq_types_pkg::word_count_t buffer_size,   // words per record
  input  acq_types_pkg::buf_word_t   rd_data,       // from the sample buffer
  output acq_types_pkg::buf_addr_t   rd_addr,
  output acq_types_pkg::buf_word_t   out_data,
  output logic                       out_valid,     // no back-pressure
  output logic                       out_last,
  header_if.reader                   hdr
);
  import acq_types_pkg::*;
  import acq_state_pkg::*;

  rd_state_t   state;
  word_count_t cnt;          // header words, then data words
  buf_addr_t   addr_q;       // address for the following data cycle
  logic        first_data;
  logic        last_hdr;
  logic        last_data;
  logic        issue;        // a header pop or buffer read this cycle
  logic        data_sel;     // output stage source, high for buffer data

  assign hdr.rd_en = (state == RD_HDR);   // 3 back-to-back pops

  assign first_data = (state == RD_DATA) && (cnt == '0);
  assign last_hdr   = (cnt == word_count_t'(`ACQ_HDR_WORDS - 1));
  assign last_data  = (cnt == buffer_size - 1'b1);
  assign issue      = (state == RD_HDR) || (state == RD_DATA);

  // start address is on dout right when the window opens
  assign rd_addr = first_data ? hdr.dout[`ACQ_ADDR_W-1:0] : addr_q;

  ////////////////////////////////////////
  // sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= RD_IDLE;
      cnt    <= '0;
      addr_q <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (!hdr.empty) begin
            state <= RD_HDR;
            cnt   <= '0;
          end
        end
        RD_HDR: begin
          if (last_hdr) begin
            state <= RD_DATA;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RD_DATA: begin
          // circular walk, wraps at buffer_size
          addr_q <= ({1'b0, rd_addr} == buffer_size - 1'b1) ? '0 : rd_addr + 1'b1;
          if (last_data) begin
            state <= RD_IDLE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // output stage, lines up with the 1-cycle read of fifo and buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      data_sel  <= 1'b0;
    end else begin
      out_valid <= issue;
      out_last  <= (state == RD_DATA) && last_data;
      data_sel  <= (state == RD_DATA);
    end
  end

  assign out_data = data_sel ? rd_data : hdr.dout;   // header words first

endmodule

// File: hdl/channel_acq_top.sv
module channel_acq_top (
  input  logic                       clk,
  input  logic                       reset,              // sync, active high
  input  logic                       arm,
  input  logic                       trig,
  input  logic                       trig_num_we,
  input  acq_types_pkg::word_count_t buffer_size,
  input  acq_types_pkg::word_count_t post_trig_size,
  input  acq_types_pkg::chan_num_t   channel_num,
  input  acq_types_pkg::trig_num_t   initial_trig_num,
  input  acq_types_pkg::sample_t     adc_sample_a,
  input  acq_types_pkg::sample_t     adc_sample_b,
  output logic                       acq_done,
  output acq_types_pkg::trig_num_t   current_trig_num,
  output acq_types_pkg::buf_word_t   out_data,
  output logic                       out_valid,
  output logic                       out_last
);
  import acq_types_pkg::*;

  // sample buffer ports
  logic      buf_wr_en;
  buf_addr_t buf_wr_addr;
  buf_addr_t buf_rd_addr;
  buf_word_t buf_rd_data;

  header_if hdr_bus ();   // controller -> fifo -> sequencer

  ////////////////////////////////////////
  acq_control u_control (
    .clk              (clk),
    .reset            (reset),
    .arm              (arm),
    .trig             (trig),
    .trig_num_we      (trig_num_we),
    .buffer_size      (buffer_size),
    .post_trig_size   (post_trig_size),
    .channel_num      (channel_num),
    .initial_trig_num (initial_trig_num),
    .acq_done         (acq_done),
    .wr_en            (buf_wr_en),
    .wr_addr          (buf_wr_addr),
    .current_trig_num (current_trig_num),
    .hdr              (hdr_bus.writer)
  );

  sample_buffer u_buffer (
    .clk          (clk),
    .adc_sample_a (adc_sample_a),
    .adc_sample_b (adc_sample_b),
    .wr_en        (buf_wr_en),
    .wr_addr      (buf_wr_addr),
    .rd_addr      (buf_rd_addr),
    .rd_data      (buf_rd_data)
  );

  header_fifo u_hdr_fifo (
    .clk   (clk),
    .reset (reset),
    .hdr   (hdr_bus.fifo)
  );

  readout_sequencer u_readout (
    .clk         (clk),
    .reset       (reset),
    .buffer_size (buffer_size),
    .rd_data     (buf_rd_data),
    .rd_addr     (buf_rd_addr),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_last    (out_last),
    .hdr         (hdr_bus.reader)
  );

endmodule

// File: sim/channel_acq_properties.sv
module channel_acq_properties (
  input logic clk,
  input logic reset,
  input logic wr_en,       // buffer write strobe
  input logic acq_done,
  input logic arm,
  input logic out_valid,
  input logic out_last,
  input logic hdr_push,    // header fifo write
  input logic hdr_full
);

  ////////////////////////////////////////
  // controller
  // idle, header and done only lead back to sampling through arm
  a_wr_en_states: assert property (@(posedge clk) disable iff (reset)
    (!wr_en && !arm) |=> !wr_en)
    else $error("buffer writing resumed without arm");

  // done is a level that only arm drops
  a_done_holds: assert property (@(posedge clk) disable iff (reset)
    (acq_done && !arm) |=> acq_done)
    else $error("acq_done fell without arm");

  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    hdr_push |-> !hdr_full)
    else $error("header fifo written while full");

  ////////////////////////////////////////
  // readout sequencer
  // last word of the record ends the valid run
  a_last_in_valid: assert property (@(posedge clk) disable iff (reset)
    out_last |-> (out_valid ##1 !out_valid))
    else $error("out_last not on the final valid word");

endmodule

// watches the controller and the sequencer from the top level
bind channel_acq_top channel_acq_properties u_props (
  .clk        (clk),
  .reset      (reset),
  .wr_en      (buf_wr_en),
  .acq_done   (acq_done),
  .arm        (arm),
  .out_valid  (out_valid),
  .out_last   (out_last),
  .hdr_push   (hdr_bus.wr_en),
  .hdr_full   (hdr_bus.full)
);

// File: sim/channel_acq_tb.sv
`include "acq_defines.svh"

module channel_acq_tb;
  import acq_types_pkg::*;

  localparam int MAX_TESTS = 16;
  localparam int N_FIELDS  = 12;   // golden columns after the name
  localparam int F_BS      = 0;
  localparam int F_POST    = 1;
  localparam int F_CHAN    = 2;
  localparam int F_INIT    = 3;
  localparam int F_LOAD    = 4;
  localparam int F_BASE    = 5;
  localparam int F_DELAY   = 6;
  localparam int F_HDR     = 7;    // three header words from here
  localparam int F_FIRST   = 10;
  localparam int F_LAST    = 11;

  logic        clk;
  logic        reset;
  logic        arm;
  logic        trig;
  logic        trig_num_we;
  word_count_t buffer_size;
  word_count_t post_trig_size;
  chan_num_t   channel_num;
  trig_num_t   initial_trig_num;
  sample_t     adc_sample_a;
  sample_t     adc_sample_b;
  logic        acq_done;
  trig_num_t   current_trig_num;
  buf_word_t   out_data;
  logic        out_valid;
  logic        out_last;

  string       t_name [MAX_TESTS];
  logic [31:0] t_val  [MAX_TESTS][N_FIELDS];
  int          num_tests;

  buf_word_t model [`ACQ_DEPTH];   // what each buffer address should hold
  buf_word_t got_data [$];         // collected output stream
  logic      got_last [$];
  trig_num_t exp_trig;             // number the next record should carry

  int     errors;
  int     tests_run;
  int     tests_failed;
  string  cur_test;
  integer seed;
  int     wd_limit;
  logic   wd_armed;

  channel_acq_top uut (
    .clk              (clk),
    .reset            (reset),
    .arm              (arm),
    .trig             (trig),
    .trig_num_we      (trig_num_we),
    .buffer_size      (buffer_size),
    .post_trig_size   (post_trig_size),
    .channel_num      (channel_num),
    .initial_trig_num (initial_trig_num),
    .adc_sample_a     (adc_sample_a),
    .adc_sample_b     (adc_sample_b),
    .acq_done         (acq_done),
    .current_trig_num (current_trig_num),
    .out_data         (out_data),
    .out_valid        (out_valid),
    .out_last         (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // outputs move on the rising edge, so sample them on the falling one
  always @(negedge clk) begin
    if (out_valid) begin
      got_data.push_back(out_data);
      got_last.push_back(out_last);
    end
  end

  ////////////////////////////////////////
  // helpers
  function automatic buf_word_t pack_word(sample_t a, sample_t b);
    logic [`ACQ_HALF_W-1:0] ext_a;
    logic [`ACQ_HALF_W-1:0] ext_b;
    ext_a = `ACQ_HALF_W'($signed(a));   // two's complement, sign in bit 12
    ext_b = `ACQ_HALF_W'($signed(b));
    return {ext_b, ext_a};
  endfunction

  task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
    $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic close_test(int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - errs_before);
    end
  endtask

  task automatic read_golden();
    int          fd;
    int          n;
    int          f;
    string       line;
    string       name;
    logic [31:0] v [N_FIELDS];
    num_tests = 0;
    fd = $fopen("sim/channel_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/channel_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin   // skip comments and blank lines
          n = $sscanf(line, "%s %d %d %h %h %d %h %d %h %h %h %h %h", name,
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                      v[10], v[11]);
          if (n == 13) begin
            t_name[num_tests] = name;
            for (f = 0; f < N_FIELDS; f++) begin
              t_val[num_tests][f] = v[f];
            end
            num_tests++;
          end
        end
      end
      $fclose(fd);
      if (num_tests == 0) begin
        $display("no tests found in sim/channel_golden.txt");
        errors++;
      end
    end
  endtask

  // fill, delay, post, header, readout and gap per test, 4 units a cycle, doubled
  function automatic int watchdog_limit();
    int cycles;
    int i;
    cycles = 40;   // reset and the idle check
    for (i = 0; i < num_tests; i++) begin
      cycles += t_val[i][F_BS] + t_val[i][F_DELAY] + t_val[i][F_POST] + 1;
      cycles += 3 + t_val[i][F_BS] + 6 + 16;
    end
    return cycles * 4 * 2;
  endfunction

  ////////////////////////////////////////
  // tests
  task automatic check_idle();
    int   c;
    int   errs_before;
    logic seen;
    cur_test = "idle_after_reset";
    errs_before = errors;
    seen = 1'b0;
    for (c = 0; c < 20 && !seen; c++) begin
      @(negedge clk);
      if (acq_done !== 1'b0) begin
        report_mismatch("acq_done", 32'd0, 32'(acq_done));
        seen = 1'b1;
      end
      if (out_valid !== 1'b0) begin
        report_mismatch("out_valid", 32'd0, 32'(out_valid));
        seen = 1'b1;
      end
    end
    close_test(errs_before);
  endtask

  task automatic run_test(int i);
    int          bs;
    int          post;
    int          trig_k;
    int          start;
    int          n_words;
    int          k;
    int          j;
    int          w;
    int          gap;
    int          errs_before;
    logic [31:0] base;
    sample_t     a;
    cur_test = t_name[i];
    errs_before = errors;
    bs = t_val[i][F_BS];
    post = t_val[i][F_POST];
    base = t_val[i][F_BASE];
    trig_k = bs + int'(t_val[i][F_DELAY]);   // cycle of the real trigger
    start = (trig_k % bs + post + 1) % bs;
    n_words = `ACQ_HDR_WORDS + bs;
    got_data.delete();
    got_last.delete();

    // arm, with an optional trigger number load on the same cycle
    @(negedge clk);
    buffer_size = word_count_t'(bs);
    post_trig_size = word_count_t'(post);
    channel_num = t_val[i][F_CHAN];
    initial_trig_num = t_val[i][F_INIT];
    trig_num_we = t_val[i][F_LOAD][0];
    arm = 1'b1;
    if (t_val[i][F_LOAD][0]) begin
      exp_trig = t_val[i][F_INIT];
    end
    @(negedge clk);
    arm = 1'b0;
    trig_num_we = 1'b0;

    // k counts words written since arm
    for (k = 0; k <= trig_k + post; k++) begin
      a = sample_t'(base + k);
      adc_sample_a = a;
      adc_sample_b = ~a;
      model[k % bs] = pack_word(a, ~a);
      trig = (k == trig_k) || (k == bs / 2);   // the mid-fill pulse must be ignored
      if (k == trig_k && (acq_done || got_data.size() != 0)) begin
        $display("test %s: a record appeared before the trigger after the fill", cur_test);
        errors++;
      end
      @(negedge clk);
    end
    trig = 1'b0;

    for (w = 0; w < 10 && !acq_done; w++) begin
      @(negedge clk);
    end
    if (!acq_done) begin
      $display("test %s: acq_done did not rise after the post-trigger words", cur_test);
      errors++;
    end else begin
      for (w = 0; w < bs + 20 && got_data.size() < n_words; w++) begin
        @(negedge clk);
      end
      repeat (4) @(negedge clk);   // catch any extra words
      if (got_data.size() != n_words) begin
        report_mismatch("word count", 32'(n_words), 32'(got_data.size()));
      end else begin
        for (j = 0; j < n_words; j++) begin
          if (got_last[j] !== (j == n_words - 1)) begin
            report_mismatch($sformatf("out_last at word %0d", j), 32'(j == n_words - 1),
                            32'(got_last[j]));
          end
        end
        for (j = 0; j < `ACQ_HDR_WORDS; j++) begin
          if (got_data[j] !== t_val[i][F_HDR + j]) begin
            report_mismatch($sformatf("header word %0d", j), t_val[i][F_HDR + j], got_data[j]);
          end
        end
        if (got_data[3] !== t_val[i][F_FIRST]) begin
          report_mismatch("first data word", t_val[i][F_FIRST], got_data[3]);
        end
        if (got_data[n_words - 1] !== t_val[i][F_LAST]) begin
          report_mismatch("last data word", t_val[i][F_LAST], got_data[n_words - 1]);
        end
        for (j = 0; j < bs; j++) begin
          if (got_data[3 + j] !== model[(start + j) % bs]) begin
            report_mismatch($sformatf("data word %0d", j), model[(start + j) % bs],
                            got_data[3 + j]);
          end
        end
      end
      if (current_trig_num !== trig_num_t'(exp_trig + 1)) begin
        report_mismatch("current_trig_num", trig_num_t'(exp_trig + 1), current_trig_num);
      end
    end
    exp_trig = trig_num_t'(exp_trig + 1);
    close_test(errs_before);

    gap = 2 + ($unsigned($random(seed)) % 8);
    repeat (gap) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    seed             = 38;
    reset            = 1'b1;
    arm              = 1'b0;
    trig             = 1'b0;
    trig_num_we      = 1'b0;
    buffer_size      = '0;
    post_trig_size   = '0;
    channel_num      = '0;
    initial_trig_num = '0;
    adc_sample_a     = '0;
    adc_sample_b     = '0;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    exp_trig         = '0;   // trigger number after reset
    wd_armed         = 1'b0;
    read_golden();
    wd_limit = watchdog_limit();
    wd_armed = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    check_idle();
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (wd_armed);
    #(wd_limit);
    $display("watchdog expired after %0d time units, the run hung", wd_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: sim/channel_golden.txt
# name buffer_size post_trig_size channel(h) init_trig(h) load base(h) trig_delay
#   then expected header channel(h) trig_num(h) start(h), first data(h), last data(h)
# sample a = base + words since arm (13 bits), sample b = ~a
basic      8  3  00000005 00000010 1 0000 2  00000005 00000010 00000006 fff90006 fff2000d
wrap_neg   16 20 00000002 00000000 0 0ff8 5  00000002 00000011 0000000a 0fedf012 0fdef021
ovr_post0  5  0  abcd0003 ffffffff 1 1ffb 0  abcd0003 ffffffff 00000001 0003fffc ffff0000
full_win   7  6  00000007 00000000 0 0123 13 00000007 00000000 00000006 fec80137 fec2013d

// File: sim.f
+incdir+hdl
hdl/acq_types_pkg.sv
hdl/acq_state_pkg.sv
hdl/acq_if.sv
hdl/acq_control.sv
hdl/sample_buffer.sv
hdl/header_fifo.sv
hdl/readout_sequencer.sv
hdl/channel_acq_top.sv
sim/channel_acq_properties.sv
sim/channel_acq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= channel_acq_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
